// ==== Makefile ====
# Verilator build and run for the instruction dispatcher testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_instr_dispatch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard include/*.svh source/*.sv verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The verdict is the presence of the pass line in the simulation output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+include
source/dispatch_pkg.sv
source/sample_fifo.sv
source/route_table.sv
source/fanout_dispatcher.sv
source/credit_output.sv
source/instr_dispatch_top.sv
verification/clock_gen.sv
verification/tb_instr_dispatch.sv

// ==== include/dispatch_consts.svh ====
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// --------------------------------------
// Source and channel counts
// --------------------------------------
`define DISP_N_SRC 8
`define DISP_N_CHAN 8
`define DISP_W_SRC 3
`define DISP_W_CHAN 3

// Sample word width as delivered by the ADC front end
`define DISP_W_DATA 18

// --------------------------------------
// Input FIFO and output credits
// --------------------------------------
`define DISP_FIFO_DEPTH 16
`define DISP_W_FIFO_PTR 4
// Matches the depth of the downstream input buffer
`define DISP_OUT_CREDITS 4
`define DISP_W_CREDIT 3

// Configuration port addresses
`define DISP_W_CFG_ADDR 2
`define DISP_CFG_CHAN_EN 2'd0
`define DISP_CFG_SRC_SEL 2'd1

`endif

// ==== source/credit_output.sv ====
`include "dispatch_consts.svh"

module credit_output import dispatch_pkg::*; (
   input  logic    clk_in,
   input  logic    rst,
   input  logic    issue,
   input  chan_t   issue_chan,
   input  sample_t issue_data,
   input  logic    credit_return,
   output logic    has_credit,
   output logic    instr_valid,
   output chan_t   instr_chan,
   output sample_t instr_data
);

   // --------------------------------------
   // Credit counter
   // --------------------------------------
   credit_cnt_t credits;

   // Issue spends a credit and each returned beat gives one back
   always_ff @(posedge clk_in) begin
      if (rst) begin
         credits <= credit_cnt_t'(`DISP_OUT_CREDITS);
      end else begin
         case ({issue, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   assign has_credit = (credits != '0);

   // Output register stage with valid one cycle after the issue edge
   always_ff @(posedge clk_in) begin
      if (rst)
         instr_valid <= 1'b0;
      else
         instr_valid <= issue;
   end

   always_ff @(posedge clk_in) begin
      if (issue) begin
         instr_chan <= issue_chan;
         instr_data <= issue_data;
      end
   end

   // Count stays within the downstream buffer depth
   a_credit_max: assert property (
      @(posedge clk_in) disable iff (rst) credits <= `DISP_OUT_CREDITS
   );

   // An issue without a credit would wrap the count
   a_no_underflow: assert property (
      @(posedge clk_in) disable iff (rst) issue |-> (credits != '0)
   );

   // At full count nothing is outstanding, so no credit may come back
   a_no_extra_return: assert property (
      @(posedge clk_in) disable iff (rst)
         credit_return |-> (credits != `DISP_OUT_CREDITS)
   );

endmodule

// ==== source/dispatch_pkg.sv ====
`include "dispatch_consts.svh"

package dispatch_pkg;

   // ADC source number
   typedef logic [`DISP_W_SRC-1:0] src_t;

   // Source select of a channel
   // Top bit set marks the channel as unmapped
   typedef logic [`DISP_W_SRC:0] src_sel_t;

   // Output channel number
   typedef logic [`DISP_W_CHAN-1:0] chan_t;

   // Channel number on the config port with one extra bit for range checks
   typedef logic [`DISP_W_CHAN:0] cfg_chan_t;

   // Sample data word
   typedef logic [`DISP_W_DATA-1:0] sample_t;

   // One bit per output channel
   typedef logic [`DISP_N_CHAN-1:0] chan_map_t;

   // Downstream credit count from 0 up to DISP_OUT_CREDITS
   typedef logic [`DISP_W_CREDIT-1:0] credit_cnt_t;

   // Configuration register address
   typedef logic [`DISP_W_CFG_ADDR-1:0] cfg_addr_t;

endpackage

// ==== source/fanout_dispatcher.sv ====
`include "dispatch_consts.svh"

module fanout_dispatcher import dispatch_pkg::*; (
   input  logic      clk_in,
   input  logic      rst,
   input  logic      head_valid,
   input  src_t      head_src,
   input  sample_t   head_data,
   output logic      pop,
   output src_t      lookup_src,
   input  chan_map_t target_map,
   input  logic      has_credit,
   output logic      issue,
   output chan_t     issue_chan,
   output sample_t   issue_data
);

   // --------------------------------------
   // Remaining work for the head sample
   // --------------------------------------
   // Channels already served for the current head
   chan_map_t sent;
   chan_map_t remaining;
   chan_map_t pick_onehot;
   logic      any_left;
   logic      is_last;

   // Route lookup uses the source of the FIFO head
   assign lookup_src = head_src;

   assign remaining = target_map & ~sent;
   assign any_left  = (remaining != '0);

   // Isolate the lowest set bit
   assign pick_onehot = remaining & (~remaining + 1'b1);

   // Only one channel left means this issue finishes the head
   assign is_last = (remaining == pick_onehot);

   // Channel number of the lowest remaining bit
   // Scanning downward lets the lowest index win
   always_comb begin
      issue_chan = '0;
      for (int i = `DISP_N_CHAN - 1; i >= 0; i--) begin
         if (remaining[i])
            issue_chan = chan_t'(i);
      end
   end

   // --------------------------------------
   // Issue and pop
   // --------------------------------------
   // One instruction per cycle and only while downstream holds space
   assign issue      = head_valid && any_left && has_credit;
   assign issue_data = head_data;

   // Pop on the last issue, or at once when nothing is routed
   // Popping together with the last issue lets the next head
   // go out in the following cycle
   assign pop = head_valid && (!any_left || (issue && is_last));

   // Sent mask is held while stalled on credit
   always_ff @(posedge clk_in) begin
      if (rst)
         sent <= '0;
      else if (pop)
         sent <= '0;
      else if (issue)
         sent <= sent | pick_onehot;
   end

   // Encoder and bit isolation agree on the channel that goes out
   a_pick_matches_chan: assert property (
      @(posedge clk_in) disable iff (rst)
         issue |-> (pick_onehot == (chan_map_t'(1) << issue_chan))
   );

endmodule

// ==== source/instr_dispatch_top.sv ====
module instr_dispatch_top import dispatch_pkg::*; (
   input  logic      clk_in,
   input  logic      rst,
   // ADC samples without a ready
   input  logic      sample_valid,
   input  src_t      sample_src,
   input  sample_t   sample_data,
   // Routing configuration
   input  logic      cfg_wr_en,
   input  cfg_addr_t cfg_addr,
   input  cfg_chan_t cfg_chan,
   input  src_sel_t  cfg_data,
   // Toward the controller pipeline
   output logic      instr_valid,
   output chan_t     instr_chan,
   output sample_t   instr_data,
   input  logic      credit_return,
   // Sticky input overflow
   output logic      overflow
);

   // FIFO head toward the dispatcher
   logic      head_valid;
   src_t      head_src;
   sample_t   head_data;
   logic      pop;

   // Route lookup
   src_t      lookup_src;
   chan_map_t target_map;

   // Issue path into the output stage
   logic      has_credit;
   logic      issue;
   chan_t     issue_chan;
   sample_t   issue_data;

   // --------------------------------------
   // Input side
   // --------------------------------------
   sample_fifo u_sample_fifo (
      .clk_in     (clk_in),
      .rst        (rst),
      .wr_en      (sample_valid),
      .wr_src     (sample_src),
      .wr_data    (sample_data),
      .pop        (pop),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .overflow   (overflow)
   );

   // --------------------------------------
   // Routing and fan-out
   // --------------------------------------
   route_table u_route_table (
      .clk_in     (clk_in),
      .rst        (rst),
      .cfg_wr_en  (cfg_wr_en),
      .cfg_addr   (cfg_addr),
      .cfg_chan   (cfg_chan),
      .cfg_data   (cfg_data),
      .lookup_src (lookup_src),
      .target_map (target_map)
   );

   fanout_dispatcher u_fanout_dispatcher (
      .clk_in     (clk_in),
      .rst        (rst),
      .head_valid (head_valid),
      .head_src   (head_src),
      .head_data  (head_data),
      .pop        (pop),
      .lookup_src (lookup_src),
      .target_map (target_map),
      .has_credit (has_credit),
      .issue      (issue),
      .issue_chan (issue_chan),
      .issue_data (issue_data)
   );

   // --------------------------------------
   // Output side
   // --------------------------------------
   credit_output u_credit_output (
      .clk_in        (clk_in),
      .rst           (rst),
      .issue         (issue),
      .issue_chan    (issue_chan),
      .issue_data    (issue_data),
      .credit_return (credit_return),
      .has_credit    (has_credit),
      .instr_valid   (instr_valid),
      .instr_chan    (instr_chan),
      .instr_data    (instr_data)
   );

endmodule

// ==== source/route_table.sv ====
`include "dispatch_consts.svh"

module route_table import dispatch_pkg::*; (
   input  logic      clk_in,
   input  logic      rst,
   input  logic      cfg_wr_en,
   input  cfg_addr_t cfg_addr,
   input  cfg_chan_t cfg_chan,
   input  src_sel_t  cfg_data,
   input  src_t      lookup_src,
   output chan_map_t target_map
);

   // Select value that leaves a channel without a source
   localparam src_sel_t SEL_UNMAPPED = src_sel_t'(`DISP_N_SRC);

   // --------------------------------------
   // Configuration registers
   // --------------------------------------
   chan_map_t chan_en;
   src_sel_t  chan_sel [`DISP_N_CHAN];

   // Source to channel map, one row per source
   chan_map_t src_map [`DISP_N_SRC];

   logic     cfg_chan_ok;
   chan_t    cfg_idx;
   src_sel_t old_sel;
   logic     old_valid;
   src_t     old_src;
   logic     new_valid;
   src_t     new_src;

   // Out of range channel numbers are ignored
   assign cfg_chan_ok = (cfg_chan < `DISP_N_CHAN);
   assign cfg_idx     = cfg_chan[`DISP_W_CHAN-1:0];

   // Previous route of the channel being written
   assign old_sel   = chan_sel[cfg_idx];
   assign old_valid = (old_sel < `DISP_N_SRC);
   assign old_src   = old_sel[`DISP_W_SRC-1:0];

   // New route is only registered in the map if it names a real source
   assign new_valid = (cfg_data < `DISP_N_SRC);
   assign new_src   = cfg_data[`DISP_W_SRC-1:0];

   // Register writes and incremental map update
   always_ff @(posedge clk_in) begin
      if (rst) begin
         chan_en <= '0;
         for (int c = 0; c < `DISP_N_CHAN; c++)
            chan_sel[c] <= SEL_UNMAPPED;
         for (int s = 0; s < `DISP_N_SRC; s++)
            src_map[s] <= '0;
      end else if (cfg_wr_en && cfg_chan_ok) begin
         case (cfg_addr)
            `DISP_CFG_CHAN_EN: begin
               chan_en[cfg_idx] <= cfg_data[0];
            end
            `DISP_CFG_SRC_SEL: begin
               chan_sel[cfg_idx] <= cfg_data;
               // Drop the old route first
               if (old_valid)
                  src_map[old_src][cfg_idx] <= 1'b0;
               // When the same source is rewritten the set below wins
               if (new_valid)
                  src_map[new_src][cfg_idx] <= 1'b1;
            end
            default: begin
            end
         endcase
      end
   end

   // --------------------------------------
   // Lookup
   // --------------------------------------
   // Disabled channels never reach the dispatcher
   assign target_map = src_map[lookup_src] & chan_en;

   // Column view of the map with one bit per source for each channel
   logic [`DISP_N_SRC-1:0] chan_col [`DISP_N_CHAN];

   always_comb begin
      for (int c = 0; c < `DISP_N_CHAN; c++) begin
         for (int s = 0; s < `DISP_N_SRC; s++)
            chan_col[c][s] = src_map[s][c];
      end
   end

   // A channel is driven by at most one source
   for (genvar c = 0; c < `DISP_N_CHAN; c++) begin : g_map_check
      a_one_source: assert property (
         @(posedge clk_in) disable iff (rst) $onehot0(chan_col[c])
      );
   end

endmodule

// ==== source/sample_fifo.sv ====
`include "dispatch_consts.svh"

module sample_fifo import dispatch_pkg::*; (
   input  logic    clk_in,
   input  logic    rst,
   input  logic    wr_en,
   input  src_t    wr_src,
   input  sample_t wr_data,
   input  logic    pop,
   output logic    head_valid,
   output src_t    head_src,
   output sample_t head_data,
   output logic    overflow
);

   // --------------------------------------
   // Storage and pointers
   // --------------------------------------
   src_t    src_mem  [`DISP_FIFO_DEPTH];
   sample_t data_mem [`DISP_FIFO_DEPTH];

   logic [`DISP_W_FIFO_PTR-1:0] wr_ptr;
   logic [`DISP_W_FIFO_PTR-1:0] rd_ptr;
   // One bit wider than the pointers so that full is representable
   logic [`DISP_W_FIFO_PTR:0]   count;

   logic full;
   logic wr_accept;

   assign full      = (count == `DISP_FIFO_DEPTH);
   // A write into a full FIFO is lost since the ADC has no back-pressure
   assign wr_accept = wr_en && !full;

   // Payload write
   always_ff @(posedge clk_in) begin
      if (wr_accept) begin
         src_mem[wr_ptr]  <= wr_src;
         data_mem[wr_ptr] <= wr_data;
      end
   end

   // Pointer and occupancy tracking
   // Depth is a power of two, so the pointers wrap on their own
   always_ff @(posedge clk_in) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_accept)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_accept, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Sticky overflow that only reset clears
   always_ff @(posedge clk_in) begin
      if (rst)
         overflow <= 1'b0;
      else if (wr_en && full)
         overflow <= 1'b1;
   end

   // Head is read straight from the array
   assign head_valid = (count != '0);
   assign head_src   = src_mem[rd_ptr];
   assign head_data  = data_mem[rd_ptr];

   // The dispatcher must only pop an entry that exists
   a_pop_needs_head: assert property (
      @(posedge clk_in) disable iff (rst) pop |-> head_valid
   );

endmodule

// ==== verification/clock_gen.sv ====
module clock_gen #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk_in
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free running clock that starts low
   initial begin
      clk_in = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_in = ~clk_in;
   end

endmodule

// ==== verification/tb_instr_dispatch.sv ====
`include "dispatch_consts.svh"

module tb_instr_dispatch
   import dispatch_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 16;
   // Rough length of each test in cycles including config writes
   localparam int TEST_CYCLES = 100 + 120 + 200 + 220 + 180 + 300;
   localparam int TIMEOUT_CYCLES = 3 * (TEST_CYCLES + 2 * RESET_CYCLES);

   // --------------------------------------
   // DUT signals
   // --------------------------------------
   logic clk_in;
   logic rst;
   logic sample_valid;
   src_t sample_src;
   sample_t sample_data;
   logic cfg_wr_en;
   cfg_addr_t cfg_addr;
   cfg_chan_t cfg_chan;
   src_sel_t cfg_data;
   logic instr_valid;
   chan_t instr_chan;
   sample_t instr_data;
   logic credit_return = 1'b0;
   logic overflow;

   // Reference routing with enable and select per channel
   logic ref_en [`DISP_N_CHAN];
   int ref_sel [`DISP_N_CHAN];

   // Expected and observed instruction beats
   int exp_chan [$];
   sample_t exp_data [$];
   int got_chan [$];
   sample_t got_data [$];

   // Downstream credit model
   bit auto_credit = 1'b1;
   int owed = 0;
   int gap = 0;
   int cyc = 0;

   int checks = 0;
   int errors = 0;
   int tests_run = 0;
   int tests_bad = 0;
   int errors_at_test_start = 0;

   clock_gen #(.PERIOD_NS(8.0)) clk_i (.clk_in(clk_in));

   instr_dispatch_top dut_i (
      .clk_in        (clk_in),
      .rst           (rst),
      .sample_valid  (sample_valid),
      .sample_src    (sample_src),
      .sample_data   (sample_data),
      .cfg_wr_en     (cfg_wr_en),
      .cfg_addr      (cfg_addr),
      .cfg_chan      (cfg_chan),
      .cfg_data      (cfg_data),
      .instr_valid   (instr_valid),
      .instr_chan    (instr_chan),
      .instr_data    (instr_data),
      .credit_return (credit_return),
      .overflow      (overflow)
   );

   // --------------------------------------
   // Monitor and credit return
   // --------------------------------------
   // Every beat owes one credit
   // With auto_credit set credits go back one per cycle with random gaps of 0 to 3
   always @(posedge clk_in) begin
      cyc = cyc + 1;
      if (rst) begin
         owed = 0;
         gap = 0;
         credit_return <= 1'b0;
      end else begin
         if (instr_valid) begin
            got_chan.push_back(int'(instr_chan));
            got_data.push_back(instr_data);
            owed = owed + 1;
         end
         if (auto_credit && owed > 0 && gap == 0) begin
            credit_return <= 1'b1;
            owed = owed - 1;
            gap = int'($urandom_range(3, 0));
         end else begin
            credit_return <= 1'b0;
            if (gap > 0)
               gap = gap - 1;
         end
      end
   end

   // Run limit
   initial begin : watchdog
      while (cyc < TIMEOUT_CYCLES)
         @(posedge clk_in);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   // --------------------------------------
   // Helpers
   // --------------------------------------
   task automatic apply_reset();
      rst <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_in);
      rst <= 1'b0;
      // All channels come out of reset disabled and unmapped
      for (int c = 0; c < `DISP_N_CHAN; c++) begin
         ref_en[c] = 1'b0;
         ref_sel[c] = `DISP_N_SRC;
      end
      exp_chan.delete();
      exp_data.delete();
      got_chan.delete();
      got_data.delete();
      auto_credit = 1'b1;
   endtask

   // One config write
   // Out of range channels leave the model untouched
   task automatic cfg_write(input cfg_addr_t addr, input int chan, input int value);
      @(posedge clk_in);
      cfg_wr_en <= 1'b1;
      cfg_addr <= addr;
      cfg_chan <= cfg_chan_t'(chan);
      cfg_data <= src_sel_t'(value);
      @(posedge clk_in);
      cfg_wr_en <= 1'b0;
      if (chan < `DISP_N_CHAN) begin
         if (addr == `DISP_CFG_CHAN_EN)
            ref_en[chan] = value[0];
         else if (addr == `DISP_CFG_SRC_SEL)
            ref_sel[chan] = value;
      end
   endtask

   // Expected beats of one sample in ascending channel order
   task automatic predict_beats(input int src, input sample_t data);
      for (int c = 0; c < `DISP_N_CHAN; c++) begin
         if (ref_en[c] && ref_sel[c] == src) begin
            exp_chan.push_back(c);
            exp_data.push_back(data);
         end
      end
   endtask

   // Drives one sample cycle
   // Consecutive calls go back to back
   task automatic send_sample(input int src, input sample_t data, input bit accepted);
      @(posedge clk_in);
      sample_valid <= 1'b1;
      sample_src <= src_t'(src);
      sample_data <= data;
      if (accepted)
         predict_beats(src, data);
   endtask

   task automatic end_samples();
      @(posedge clk_in);
      sample_valid <= 1'b0;
   endtask

   task automatic check_value(input string name, input string what,
                              input int expected, input int actual);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("mismatch %s %s: expected %0d, actual %0d", name, what, expected, actual);
      end
   endtask

   task automatic wait_for_beats(input int n);
      while (got_chan.size() < n)
         @(posedge clk_in);
   endtask

   // Waits until no credit is outstanding in the testbench
   task automatic wait_credits_home();
      while (owed != 0)
         @(posedge clk_in);
      repeat (3) @(posedge clk_in);
   endtask

   // Waits for the predicted beats and then a quiet window for extras
   task automatic drain_and_compare(input string name, input int settle);
      int n;
      wait_for_beats(exp_chan.size());
      repeat (settle) @(posedge clk_in);
      check_value(name, "beat count", exp_chan.size(), got_chan.size());
      n = (got_chan.size() < exp_chan.size()) ? got_chan.size() : exp_chan.size();
      for (int i = 0; i < n; i++) begin
         checks++;
         if (got_chan[i] != exp_chan[i] || got_data[i] != exp_data[i]) begin
            errors++;
            $display("mismatch %s beat %0d: expected chan %0d data 0x%05h, %s %0d data 0x%05h",
                     name, i, exp_chan[i], exp_data[i], "actual chan",
                     got_chan[i], got_data[i]);
         end
      end
      exp_chan.delete();
      exp_data.delete();
      got_chan.delete();
      got_data.delete();
   endtask

   task automatic report_test(input string name);
      int n;
      n = errors - errors_at_test_start;
      tests_run++;
      if (n == 0) begin
         $display("test %-20s ok", name);
      end else begin
         tests_bad++;
         $display("test %-20s %0d errors", name, n);
      end
      errors_at_test_start = errors;
   endtask

   // --------------------------------------
   // Directed tests
   // --------------------------------------
   task automatic after_reset_idle();
      check_value("after_reset", "instr_valid", 0, int'(instr_valid));
      check_value("after_reset", "overflow", 0, int'(overflow));
      // Nothing is mapped, so no instruction may appear
      send_sample(0, sample_t'($urandom()), 1'b1);
      end_samples();
      drain_and_compare("after_reset", 50);
      report_test("after_reset");
   endtask

   task automatic single_route();
      cfg_write(`DISP_CFG_CHAN_EN, 5, 1);
      cfg_write(`DISP_CFG_SRC_SEL, 5, 2);
      send_sample(2, sample_t'($urandom()), 1'b1);
      send_sample(5, sample_t'($urandom()), 1'b1);
      end_samples();
      drain_and_compare("single_route", 20);
      report_test("single_route");
   endtask

   // Written out of order and expected back in ascending order
   task automatic fan_out_order();
      cfg_write(`DISP_CFG_SRC_SEL, 6, 4);
      cfg_write(`DISP_CFG_SRC_SEL, 1, 4);
      cfg_write(`DISP_CFG_SRC_SEL, 3, 4);
      cfg_write(`DISP_CFG_CHAN_EN, 6, 1);
      cfg_write(`DISP_CFG_CHAN_EN, 1, 1);
      cfg_write(`DISP_CFG_CHAN_EN, 3, 1);
      for (int i = 0; i < 6; i++)
         send_sample(4, sample_t'($urandom()), 1'b1);
      end_samples();
      drain_and_compare("fan_out", 20);
      report_test("fan_out");
   endtask

   task automatic remap_and_disable();
      cfg_write(`DISP_CFG_SRC_SEL, 3, 7);
      cfg_write(`DISP_CFG_CHAN_EN, 1, 0);
      // Out of range channels that would alias onto 1, 6 and 5 if truncated
      cfg_write(`DISP_CFG_SRC_SEL, 9, 4);
      cfg_write(`DISP_CFG_CHAN_EN, 9, 1);
      cfg_write(`DISP_CFG_SRC_SEL, 14, 7);
      cfg_write(`DISP_CFG_CHAN_EN, 13, 0);
      send_sample(4, sample_t'($urandom()), 1'b1);
      send_sample(7, sample_t'($urandom()), 1'b1);
      send_sample(2, sample_t'($urandom()), 1'b1);
      send_sample(4, sample_t'($urandom()), 1'b1);
      end_samples();
      drain_and_compare("remap_disable", 20);
      report_test("remap_disable");
   endtask

   task automatic credit_back_pressure();
      wait_credits_home();
      cfg_write(`DISP_CFG_SRC_SEL, 0, 4);
      cfg_write(`DISP_CFG_SRC_SEL, 2, 4);
      cfg_write(`DISP_CFG_CHAN_EN, 0, 1);
      cfg_write(`DISP_CFG_CHAN_EN, 2, 1);
      auto_credit = 1'b0;
      for (int i = 0; i < 3; i++)
         send_sample(4, sample_t'($urandom()), 1'b1);
      end_samples();
      // Stall window with no credit coming back
      repeat (40) @(posedge clk_in);
      check_value("back_pressure", "beats without credit return",
                  `DISP_OUT_CREDITS, got_chan.size());
      auto_credit = 1'b1;
      drain_and_compare("back_pressure", 20);
      report_test("back_pressure");
   endtask

   task automatic fifo_overflow();
      wait_credits_home();
      auto_credit = 1'b0;
      // Spend every credit on source 7, which drives channel 3 only
      for (int i = 0; i < `DISP_OUT_CREDITS; i++)
         send_sample(7, sample_t'($urandom()), 1'b1);
      end_samples();
      wait_for_beats(`DISP_OUT_CREDITS);
      check_value("overflow", "overflow before burst", 0, int'(overflow));
      // Only the first FIFO depth worth of the burst fits
      for (int i = 0; i < `DISP_FIFO_DEPTH + 4; i++)
         send_sample(7, sample_t'($urandom()), i < `DISP_FIFO_DEPTH);
      end_samples();
      repeat (2) @(posedge clk_in);
      check_value("overflow", "overflow after burst", 1, int'(overflow));
      auto_credit = 1'b1;
      drain_and_compare("overflow", 20);
      check_value("overflow", "overflow after drain", 1, int'(overflow));
      apply_reset();
      @(posedge clk_in);
      check_value("overflow", "overflow after reset", 0, int'(overflow));
      check_value("overflow", "instr_valid after reset", 0, int'(instr_valid));
      report_test("overflow");
   endtask

   // --------------------------------------
   // Main sequence
   // --------------------------------------
   initial begin : main
      void'($urandom(32'h99ed_c118));
      rst = 1'b1;
      sample_valid = 1'b0;
      sample_src = '0;
      sample_data = '0;
      cfg_wr_en = 1'b0;
      cfg_addr = '0;
      cfg_chan = '0;
      cfg_data = '0;
      apply_reset();
      after_reset_idle();
      single_route();
      fan_out_order();
      remap_and_disable();
      credit_back_pressure();
      fifo_overflow();
      $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule
